// ==== compile.f ====
source/cpuPkg.sv
source/excPkg.sv
source/regFile.sv
source/decodeStage.sv
source/pipeControl.sv
source/idExReg.sv
source/executeStage.sv
source/coreSlice.sv
tests/coreSliceTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the coreSlice testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --top-module coreSliceTb -f compile.f -o coreSliceSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/coreSliceSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi

// ==== source/coreSlice.sv ====
`timescale 1ns/1ps

module coreSlice import cpuPkg::*, excPkg::*; (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  logic                    insValid_i,
    input  logic [dataWidth-1:0]    ins_i,
    input  logic [dataWidth-1:0]    insAddr_i,
    input  logic                    stall_i,
    output logic                    insReady_o,
    output logic                    retire_o,
    output logic [dataWidth-1:0]    retireAddr_o,
    output logic                    wbEn_o,
    output logic [regAddrWidth-1:0] wbAddr_o,
    output logic [dataWidth-1:0]    wbData_o,
    output memOpE                   memOp_o,
    output logic [dataWidth-1:0]    memAddr_o,
    output logic [dataWidth-1:0]    storeData_o,
    output logic                    cp0WriteEn_o,
    output logic [4:0]              cp0Addr_o,
    output logic [dataWidth-1:0]    cp0Data_o,
    output excCodeE                 exception_o,
    output logic [dataWidth-1:0]    badVAddr_o
);

    logic [regAddrWidth-1:0] rsAddr, rtAddr;
    logic [dataWidth-1:0]    rsData, rtData, hi, lo;
    logic                    pause, flush, bubble;

    // Decode side of the ID/EX register
    logic [dataWidth-1:0]    decInsAddr, decOperand1, decOperand2, decStoreData;
    aluOpE                   decAluOp;
    memOpE                   decMemOp;
    logic                    decWriteReg, decWriteHiLo, decWriteCP0, decReadsHiLo, decInsValid;
    logic [regAddrWidth-1:0] decWriteRegAddr;
    logic [4:0]              decWriteCP0Addr;
    excCodeE                 decException;

    // Execute side
    logic [dataWidth-1:0]    exInsAddr, exOperand1, exOperand2, exStoreData;
    aluOpE                   exAluOp;
    memOpE                   exMemOp;
    logic                    exWriteReg, exWriteHiLo, exWriteCP0, exInsValid;
    logic [regAddrWidth-1:0] exWriteRegAddr;
    logic [4:0]              exWriteCP0Addr;
    excCodeE                 exException;

    regFile regFile_inst (
        .clk(clk), .rstN_i(rstN_i),
        .rdAddrA_i(rsAddr), .rdAddrB_i(rtAddr),
        .wrEn_i(wbEn_o), .wrAddr_i(wbAddr_o), .wrData_i(wbData_o),
        .rdDataA_o(rsData), .rdDataB_o(rtData)
    );

    decodeStage decodeStage_inst (
        .ins_i(ins_i), .insAddr_i(insAddr_i), .insValid_i(insValid_i),
        .rsData_i(rsData), .rtData_i(rtData), .hi_i(hi), .lo_i(lo),
        .exWbEn_i(wbEn_o), .exWbAddr_i(wbAddr_o), .exWbData_i(wbData_o),
        .rsAddr_o(rsAddr), .rtAddr_o(rtAddr),
        .operand1_o(decOperand1), .operand2_o(decOperand2),
        .aluOp_o(decAluOp), .memOp_o(decMemOp), .storeData_o(decStoreData),
        .writeReg_o(decWriteReg), .writeRegAddr_o(decWriteRegAddr),
        .writeHiLo_o(decWriteHiLo), .writeCP0_o(decWriteCP0),
        .writeCP0Addr_o(decWriteCP0Addr), .readsHiLo_o(decReadsHiLo),
        .insValid_o(decInsValid), .exception_o(decException), .insAddr_o(decInsAddr)
    );

    pipeControl pipeControl_inst (
        .stall_i(stall_i), .exException_i(exception_o),
        .decReadsHiLo_i(decReadsHiLo), .exWritesHiLo_i(exWriteHiLo),
        .insValid_i(insValid_i),
        .pause_o(pause), .flush_o(flush), .bubble_o(bubble), .insReady_o(insReady_o)
    );

    idExReg idExReg_inst (
        .clk(clk), .rstN_i(rstN_i),
        .pause_i(pause), .flush_i(flush), .bubble_i(bubble),
        .insAddr_i(decInsAddr), .operand1_i(decOperand1), .operand2_i(decOperand2),
        .aluOp_i(decAluOp), .storeData_i(decStoreData), .memOp_i(decMemOp),
        .writeReg_i(decWriteReg), .writeRegAddr_i(decWriteRegAddr),
        .writeHiLo_i(decWriteHiLo), .writeCP0_i(decWriteCP0),
        .writeCP0Addr_i(decWriteCP0Addr), .insValid_i(decInsValid),
        .exception_i(decException),
        .insAddr_o(exInsAddr), .operand1_o(exOperand1), .operand2_o(exOperand2),
        .aluOp_o(exAluOp), .storeData_o(exStoreData), .memOp_o(exMemOp),
        .writeReg_o(exWriteReg), .writeRegAddr_o(exWriteRegAddr),
        .writeHiLo_o(exWriteHiLo), .writeCP0_o(exWriteCP0),
        .writeCP0Addr_o(exWriteCP0Addr), .insValid_o(exInsValid),
        .exception_o(exException)
    );

    executeStage executeStage_inst (
        .clk(clk), .rstN_i(rstN_i), .pause_i(pause),
        .insAddr_i(exInsAddr), .operand1_i(exOperand1), .operand2_i(exOperand2),
        .aluOp_i(exAluOp), .storeData_i(exStoreData), .memOp_i(exMemOp),
        .writeReg_i(exWriteReg), .writeRegAddr_i(exWriteRegAddr),
        .writeHiLo_i(exWriteHiLo), .writeCP0_i(exWriteCP0),
        .writeCP0Addr_i(exWriteCP0Addr), .insValid_i(exInsValid),
        .exception_i(exException),
        .retire_o(retire_o), .retireAddr_o(retireAddr_o),
        .wbEn_o(wbEn_o), .wbAddr_o(wbAddr_o), .wbData_o(wbData_o),
        .memOp_o(memOp_o), .memAddr_o(memAddr_o), .storeData_o(storeData_o),
        .cp0WriteEn_o(cp0WriteEn_o), .cp0Addr_o(cp0Addr_o), .cp0Data_o(cp0Data_o),
        .hi_o(hi), .lo_o(lo), .exception_o(exception_o), .badVAddr_o(badVAddr_o)
    );

endmodule

// ==== source/cpuPkg.sv ====
package cpuPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int numRegs      = 32;

    typedef enum logic [4:0] {
        ALU_NOP  = 5'd0,
        ALU_ADD  = 5'd1,
        ALU_ADDU = 5'd2,
        ALU_SUB  = 5'd3,
        ALU_AND  = 5'd4,
        ALU_OR   = 5'd5,
        ALU_XOR  = 5'd6,
        ALU_SLT  = 5'd7,
        ALU_SLL  = 5'd8,
        ALU_LUI  = 5'd9,
        ALU_MULT = 5'd10,
        ALU_MFHI = 5'd11,
        ALU_MFLO = 5'd12,
        ALU_PASS = 5'd13
    } aluOpE;

    typedef enum logic [2:0] {
        MEM_NOP = 3'd0,
        MEM_LW  = 3'd1,
        MEM_SW  = 3'd2
    } memOpE;

    // Primary opcodes
    localparam logic [5:0] opSpecial = 6'b000000;
    localparam logic [5:0] opAddi    = 6'b001000;
    localparam logic [5:0] opOri     = 6'b001101;
    localparam logic [5:0] opLui     = 6'b001111;
    localparam logic [5:0] opCop0    = 6'b010000;
    localparam logic [5:0] opLw      = 6'b100011;
    localparam logic [5:0] opSw      = 6'b101011;
    localparam logic [4:0] cop0Mt    = 5'b00100;

    // SPECIAL function codes
    localparam logic [5:0] fnSll  = 6'b000000;
    localparam logic [5:0] fnMfhi = 6'b010000;
    localparam logic [5:0] fnMflo = 6'b010010;
    localparam logic [5:0] fnMult = 6'b011000;
    localparam logic [5:0] fnAdd  = 6'b100000;
    localparam logic [5:0] fnAddu = 6'b100001;
    localparam logic [5:0] fnSub  = 6'b100010;
    localparam logic [5:0] fnAnd  = 6'b100100;
    localparam logic [5:0] fnOr   = 6'b100101;
    localparam logic [5:0] fnXor  = 6'b100110;
    localparam logic [5:0] fnSlt  = 6'b101010;

endpackage

// ==== source/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage import cpuPkg::*, excPkg::*; (
    input  logic [dataWidth-1:0]    ins_i,
    input  logic [dataWidth-1:0]    insAddr_i,
    input  logic                    insValid_i,
    input  logic [dataWidth-1:0]    rsData_i,
    input  logic [dataWidth-1:0]    rtData_i,
    input  logic [dataWidth-1:0]    hi_i,
    input  logic [dataWidth-1:0]    lo_i,
    input  logic                    exWbEn_i,
    input  logic [regAddrWidth-1:0] exWbAddr_i,
    input  logic [dataWidth-1:0]    exWbData_i,
    output logic [regAddrWidth-1:0] rsAddr_o,
    output logic [regAddrWidth-1:0] rtAddr_o,
    output logic [dataWidth-1:0]    operand1_o,
    output logic [dataWidth-1:0]    operand2_o,
    output aluOpE                   aluOp_o,
    output memOpE                   memOp_o,
    output logic [dataWidth-1:0]    storeData_o,
    output logic                    writeReg_o,
    output logic [regAddrWidth-1:0] writeRegAddr_o,
    output logic                    writeHiLo_o,
    output logic                    writeCP0_o,
    output logic [4:0]              writeCP0Addr_o,
    output logic                    readsHiLo_o,
    output logic                    insValid_o,
    output excCodeE                 exception_o,
    output logic [dataWidth-1:0]    insAddr_o
);

    logic [5:0]              opcode;
    logic [5:0]              funct;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] rd;
    logic [4:0]              sa;
    logic [15:0]             imm;
    logic [dataWidth-1:0]    rsVal;
    logic [dataWidth-1:0]    rtVal;
    logic [dataWidth-1:0]    signImm;
    logic [dataWidth-1:0]    zeroImm;
    logic                    reserved;

    assign opcode  = ins_i[31:26];
    assign rs      = ins_i[25:21];
    assign rt      = ins_i[20:16];
    assign rd      = ins_i[15:11];
    assign sa      = ins_i[10:6];
    assign funct   = ins_i[5:0];
    assign imm     = ins_i[15:0];
    assign signImm = {{16{imm[15]}}, imm};
    assign zeroImm = {16'b0, imm};

    assign rsAddr_o = rs;
    assign rtAddr_o = rt;

    // Forward the value execute writes at the end of this cycle
    assign rsVal = (exWbEn_i && exWbAddr_i == rs && rs != '0) ? exWbData_i : rsData_i;
    assign rtVal = (exWbEn_i && exWbAddr_i == rt && rt != '0) ? exWbData_i : rtData_i;

    always_comb begin
        operand1_o     = rsVal;
        operand2_o     = rtVal;
        aluOp_o        = ALU_NOP;
        memOp_o        = MEM_NOP;
        storeData_o    = rtVal;
        writeReg_o     = 1'b0;
        writeRegAddr_o = rt;
        writeHiLo_o    = 1'b0;
        writeCP0_o     = 1'b0;
        readsHiLo_o    = 1'b0;
        reserved       = 1'b0;
        case (opcode)
            opSpecial: begin
                writeReg_o     = 1'b1;
                writeRegAddr_o = rd;
                case (funct)
                    fnAdd:  aluOp_o = ALU_ADD;
                    fnAddu: aluOp_o = ALU_ADDU;
                    fnSub:  aluOp_o = ALU_SUB;
                    fnAnd:  aluOp_o = ALU_AND;
                    fnOr:   aluOp_o = ALU_OR;
                    fnXor:  aluOp_o = ALU_XOR;
                    fnSlt:  aluOp_o = ALU_SLT;
                    fnSll: begin
                        aluOp_o    = ALU_SLL;
                        operand1_o = rtVal;
                        operand2_o = {27'b0, sa};
                    end
                    fnMult: begin
                        aluOp_o     = ALU_MULT;
                        writeReg_o  = 1'b0;
                        writeHiLo_o = 1'b1;
                    end
                    fnMfhi: begin
                        aluOp_o     = ALU_MFHI;
                        operand1_o  = hi_i;
                        readsHiLo_o = 1'b1;
                    end
                    fnMflo: begin
                        aluOp_o     = ALU_MFLO;
                        operand1_o  = lo_i;
                        readsHiLo_o = 1'b1;
                    end
                    default: reserved = 1'b1;
                endcase
            end
            opAddi: begin
                aluOp_o    = ALU_ADD;
                operand2_o = signImm;
                writeReg_o = 1'b1;
            end
            opOri: begin
                aluOp_o    = ALU_OR;
                operand2_o = zeroImm;
                writeReg_o = 1'b1;
            end
            opLui: begin
                aluOp_o    = ALU_LUI;
                operand2_o = zeroImm;
                writeReg_o = 1'b1;
            end
            opLw, opSw: begin
                // Address add never traps on overflow
                aluOp_o    = ALU_ADDU;
                operand2_o = signImm;
                memOp_o    = (opcode == opLw) ? MEM_LW : MEM_SW;
            end
            opCop0: begin
                if (rs == cop0Mt) begin
                    aluOp_o    = ALU_PASS;
                    operand1_o = rtVal;
                    case (rd)
                        cp0Status, cp0Cause: writeCP0_o = 1'b1;
                        // BadVAddr is read-only and drops the write
                        cp0BadVAddr: writeCP0_o = 1'b0;
                        default: writeCP0_o = 1'b0;
                    endcase
                end else begin
                    reserved = 1'b1;
                end
            end
            default: reserved = 1'b1;
        endcase

        if (reserved) begin
            aluOp_o     = ALU_NOP;
            memOp_o     = MEM_NOP;
            writeReg_o  = 1'b0;
            writeHiLo_o = 1'b0;
            readsHiLo_o = 1'b0;
        end
    end

    assign writeCP0Addr_o = writeCP0_o ? rd : cp0NoAddr;
    assign exception_o    = (insValid_i && reserved) ? EXC_RESERVED : EXC_NONE;
    assign insValid_o     = insValid_i;
    assign insAddr_o      = insAddr_i;

endmodule

// ==== source/excPkg.sv ====
package excPkg;

    // Values follow the MIPS Cause.ExcCode field
    typedef enum logic [3:0] {
        EXC_NONE      = 4'h0,
        EXC_ADDRSTORE = 4'h5,
        EXC_RESERVED  = 4'hA,
        EXC_OVERFLOW  = 4'hC
    } excCodeE;

    localparam logic [4:0] cp0NoAddr   = 5'd0;
    localparam logic [4:0] cp0BadVAddr = 5'd8;
    localparam logic [4:0] cp0Status   = 5'd12;
    localparam logic [4:0] cp0Cause    = 5'd13;

endpackage

// ==== source/executeStage.sv ====
`timescale 1ns/1ps

module executeStage import cpuPkg::*, excPkg::*; (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  logic                    pause_i,
    input  logic [dataWidth-1:0]    insAddr_i,
    input  logic [dataWidth-1:0]    operand1_i,
    input  logic [dataWidth-1:0]    operand2_i,
    input  aluOpE                   aluOp_i,
    input  logic [dataWidth-1:0]    storeData_i,
    input  memOpE                   memOp_i,
    input  logic                    writeReg_i,
    input  logic [regAddrWidth-1:0] writeRegAddr_i,
    input  logic                    writeHiLo_i,
    input  logic                    writeCP0_i,
    input  logic [4:0]              writeCP0Addr_i,
    input  logic                    insValid_i,
    input  excCodeE                 exception_i,
    output logic                    retire_o,
    output logic [dataWidth-1:0]    retireAddr_o,
    output logic                    wbEn_o,
    output logic [regAddrWidth-1:0] wbAddr_o,
    output logic [dataWidth-1:0]    wbData_o,
    output memOpE                   memOp_o,
    output logic [dataWidth-1:0]    memAddr_o,
    output logic [dataWidth-1:0]    storeData_o,
    output logic                    cp0WriteEn_o,
    output logic [4:0]              cp0Addr_o,
    output logic [dataWidth-1:0]    cp0Data_o,
    output logic [dataWidth-1:0]    hi_o,
    output logic [dataWidth-1:0]    lo_o,
    output excCodeE                 exception_o,
    output logic [dataWidth-1:0]    badVAddr_o
);

    logic [dataWidth-1:0]   result;
    logic [2*dataWidth-1:0] product;
    logic                   overflow;
    logic                   misaligned;
    logic                   commit;

    always_comb begin
        case (aluOp_i)
            ALU_ADD, ALU_ADDU: result = operand1_i + operand2_i;
            ALU_SUB:  result = operand1_i - operand2_i;
            ALU_AND:  result = operand1_i & operand2_i;
            ALU_OR:   result = operand1_i | operand2_i;
            ALU_XOR:  result = operand1_i ^ operand2_i;
            ALU_SLT:  result = {31'b0, $signed(operand1_i) < $signed(operand2_i)};
            ALU_SLL:  result = operand1_i << operand2_i[4:0];
            ALU_LUI:  result = {operand2_i[15:0], 16'b0};
            // Decode already picked HI or LO into operand1
            ALU_MFHI, ALU_MFLO, ALU_PASS: result = operand1_i;
            default:  result = '0;
        endcase
    end

    assign product = $signed(operand1_i) * $signed(operand2_i);

    assign overflow =
        (aluOp_i == ALU_ADD && operand1_i[31] == operand2_i[31] && result[31] != operand1_i[31]) ||
        (aluOp_i == ALU_SUB && operand1_i[31] != operand2_i[31] && result[31] != operand1_i[31]);
    assign misaligned = memOp_i != MEM_NOP && result[1:0] != 2'b00;

    always_comb begin
        if (!insValid_i) exception_o = EXC_NONE;
        else if (exception_i != EXC_NONE) exception_o = exception_i;
        else if (overflow) exception_o = EXC_OVERFLOW;
        else if (misaligned) exception_o = EXC_ADDRSTORE;
        else exception_o = EXC_NONE;
    end

    // Nothing leaves execute while paused or excepting
    assign commit = insValid_i && !pause_i && exception_o == EXC_NONE;

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            hi_o <= '0;
            lo_o <= '0;
        end else if (commit && writeHiLo_i) begin
            hi_o <= product[2*dataWidth-1:dataWidth];
            lo_o <= product[dataWidth-1:0];
        end
    end

    assign retire_o     = insValid_i && !pause_i;
    assign retireAddr_o = insAddr_i;
    assign wbEn_o       = commit && writeReg_i;
    assign wbAddr_o     = writeRegAddr_i;
    assign wbData_o     = result;
    assign memOp_o      = commit ? memOp_i : MEM_NOP;
    assign memAddr_o    = result;
    assign storeData_o  = storeData_i;
    assign cp0WriteEn_o = commit && writeCP0_i;
    assign cp0Addr_o    = writeCP0Addr_i;
    assign cp0Data_o    = result;
    assign badVAddr_o   = (exception_o == EXC_ADDRSTORE) ? result : '0;

endmodule

// ==== source/idExReg.sv ====
`timescale 1ns/1ps

module idExReg import cpuPkg::*, excPkg::*; (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  logic                    pause_i,
    input  logic                    flush_i,
    input  logic                    bubble_i,
    input  logic [dataWidth-1:0]    insAddr_i,
    input  logic [dataWidth-1:0]    operand1_i,
    input  logic [dataWidth-1:0]    operand2_i,
    input  aluOpE                   aluOp_i,
    input  logic [dataWidth-1:0]    storeData_i,
    input  memOpE                   memOp_i,
    input  logic                    writeReg_i,
    input  logic [regAddrWidth-1:0] writeRegAddr_i,
    input  logic                    writeHiLo_i,
    input  logic                    writeCP0_i,
    input  logic [4:0]              writeCP0Addr_i,
    input  logic                    insValid_i,
    input  excCodeE                 exception_i,
    output logic [dataWidth-1:0]    insAddr_o,
    output logic [dataWidth-1:0]    operand1_o,
    output logic [dataWidth-1:0]    operand2_o,
    output aluOpE                   aluOp_o,
    output logic [dataWidth-1:0]    storeData_o,
    output memOpE                   memOp_o,
    output logic                    writeReg_o,
    output logic [regAddrWidth-1:0] writeRegAddr_o,
    output logic                    writeHiLo_o,
    output logic                    writeCP0_o,
    output logic [4:0]              writeCP0Addr_o,
    output logic                    insValid_o,
    output excCodeE                 exception_o
);

    logic clearNow;

    // Pause wins over flush and bubble
    assign clearNow = !rstN_i || (!pause_i && (flush_i || bubble_i));

    always_ff @(posedge clk) begin
        if (clearNow) begin
            insAddr_o      <= '0;
            operand1_o     <= '0;
            operand2_o     <= '0;
            aluOp_o        <= ALU_NOP;
            storeData_o    <= '0;
            memOp_o        <= MEM_NOP;
            writeReg_o     <= 1'b0;
            writeRegAddr_o <= '0;
            writeHiLo_o    <= 1'b0;
            writeCP0_o     <= 1'b0;
            writeCP0Addr_o <= cp0NoAddr;
            insValid_o     <= 1'b0;
            exception_o    <= EXC_NONE;
        end else if (!pause_i) begin
            insAddr_o      <= insAddr_i;
            operand1_o     <= operand1_i;
            operand2_o     <= operand2_i;
            aluOp_o        <= aluOp_i;
            storeData_o    <= storeData_i;
            memOp_o        <= memOp_i;
            writeReg_o     <= writeReg_i;
            writeRegAddr_o <= writeRegAddr_i;
            writeHiLo_o    <= writeHiLo_i;
            writeCP0_o     <= writeCP0_i;
            writeCP0Addr_o <= writeCP0Addr_i;
            insValid_o     <= insValid_i;
            exception_o    <= exception_i;
        end
    end

endmodule

// ==== source/pipeControl.sv ====
`timescale 1ns/1ps

module pipeControl import excPkg::*; (
    input  logic    stall_i,
    input  excCodeE exException_i,
    input  logic    decReadsHiLo_i,
    input  logic    exWritesHiLo_i,
    input  logic    insValid_i,
    output logic    pause_o,
    output logic    flush_o,
    output logic    bubble_o,
    output logic    insReady_o
);

    assign pause_o = stall_i;

    // Younger instruction in decode is dropped behind an exception
    assign flush_o = exException_i != EXC_NONE;

    // HI/LO is only written at the end of the MULT's cycle
    assign bubble_o = insValid_i && decReadsHiLo_i && exWritesHiLo_i;

    assign insReady_o = !(pause_o || bubble_o);

endmodule

// ==== source/regFile.sv ====
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  logic [regAddrWidth-1:0] rdAddrA_i,
    input  logic [regAddrWidth-1:0] rdAddrB_i,
    input  logic                    wrEn_i,
    input  logic [regAddrWidth-1:0] wrAddr_i,
    input  logic [dataWidth-1:0]    wrData_i,
    output logic [dataWidth-1:0]    rdDataA_o,
    output logic [dataWidth-1:0]    rdDataB_o
);

    logic [dataWidth-1:0] regs [numRegs];

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn_i && wrAddr_i != '0) begin
            regs[wrAddr_i] <= wrData_i;
        end
    end

    // $zero is never written, so it reads back as zero
    assign rdDataA_o = regs[rdAddrA_i];
    assign rdDataB_o = regs[rdAddrB_i];

endmodule

// ==== tests/coreSliceTb.sv ====
`timescale 1ns/1ps

module coreSliceTb;

    localparam int timeoutCycles = 200;

    logic        clk;
    logic        rstN_i;
    logic        insValid_i;
    logic [31:0] ins_i;
    logic [31:0] insAddr_i;
    logic        stall_i;
    logic        insReady_o;
    logic        retire_o;
    logic [31:0] retireAddr_o;
    logic        wbEn_o;
    logic [4:0]  wbAddr_o;
    logic [31:0] wbData_o;
    logic [2:0]  memOp_o;
    logic [31:0] memAddr_o;
    logic [31:0] storeData_o;
    logic        cp0WriteEn_o;
    logic [4:0]  cp0Addr_o;
    logic [31:0] cp0Data_o;
    logic [3:0]  exception_o;
    logic [31:0] badVAddr_o;

    // Program and expected retire records
    logic [31:0] progAddr[$];
    logic [31:0] progIns[$];
    logic [31:0] expAddr[$];
    logic        expWbEn[$];
    logic [4:0]  expWbAddr[$];
    logic [31:0] expWbData[$];
    logic [2:0]  expMemOp[$];
    logic [31:0] expMemAddr[$];
    logic [31:0] expStoreData[$];
    logic        expCp0En[$];
    logic [4:0]  expCp0Addr[$];
    logic [31:0] expCp0Data[$];
    logic [3:0]  expExc[$];
    logic [31:0] expBadVAddr[$];

    int          recIdx;
    integer      seed;
    logic        accepted;

    coreSlice coreSlice_inst (
        .clk(clk), .rstN_i(rstN_i),
        .insValid_i(insValid_i), .ins_i(ins_i), .insAddr_i(insAddr_i),
        .stall_i(stall_i), .insReady_o(insReady_o),
        .retire_o(retire_o), .retireAddr_o(retireAddr_o),
        .wbEn_o(wbEn_o), .wbAddr_o(wbAddr_o), .wbData_o(wbData_o),
        .memOp_o(memOp_o), .memAddr_o(memAddr_o), .storeData_o(storeData_o),
        .cp0WriteEn_o(cp0WriteEn_o), .cp0Addr_o(cp0Addr_o), .cp0Data_o(cp0Data_o),
        .exception_o(exception_o), .badVAddr_o(badVAddr_o)
    );

    always #20 clk = ~clk;

    task automatic loadGolden();
        integer fd;
        int     n;
        string  line;
        logic [31:0] a, b, c, d, e, f, g, h, i, j, k, l;
        fd = $fopen("tests/golden_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open tests/golden_vectors.txt");
            $display("TESTBENCH FAILED");
            $fatal(1, "missing golden file");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                if ($sscanf(line, "I %h %h", a, b) == 2) begin
                    progAddr.push_back(a);
                    progIns.push_back(b);
                end else if ($sscanf(line, "R %h %h %h %h %h %h %h %h %h %h %h %h",
                                     a, b, c, d, e, f, g, h, i, j, k, l) == 12) begin
                    expAddr.push_back(a);
                    expWbEn.push_back(b[0]);
                    expWbAddr.push_back(c[4:0]);
                    expWbData.push_back(d);
                    expMemOp.push_back(e[2:0]);
                    expMemAddr.push_back(f);
                    expStoreData.push_back(g);
                    expCp0En.push_back(h[0]);
                    expCp0Addr.push_back(i[4:0]);
                    expCp0Data.push_back(j);
                    expExc.push_back(k[3:0]);
                    expBadVAddr.push_back(l);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic failValue(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "value mismatch");
    endtask

    // Write fields are compared only where the record enables them
    task automatic checkRetire();
        assert (recIdx < expAddr.size()) else begin
            $display("A retire at address %h came after all records were used", retireAddr_o);
            $display("TESTBENCH FAILED");
            $fatal(1, "extra retire");
        end
        assert (retireAddr_o == expAddr[recIdx])
            else failValue($sformatf("retire address %h, expected %h",
                                     retireAddr_o, expAddr[recIdx]));
        assert (exception_o == expExc[recIdx])
            else failValue($sformatf("exception %h at %h, expected %h",
                                     exception_o, retireAddr_o, expExc[recIdx]));
        assert (badVAddr_o == expBadVAddr[recIdx])
            else failValue($sformatf("badVAddr %h at %h, expected %h",
                                     badVAddr_o, retireAddr_o, expBadVAddr[recIdx]));
        assert (wbEn_o == expWbEn[recIdx])
            else failValue($sformatf("wbEn %b at %h", wbEn_o, retireAddr_o));
        if (expWbEn[recIdx]) begin
            assert (wbAddr_o == expWbAddr[recIdx] && wbData_o == expWbData[recIdx])
                else failValue($sformatf("write-back r%0d=%h at %h, expected r%0d=%h",
                                         wbAddr_o, wbData_o, retireAddr_o,
                                         expWbAddr[recIdx], expWbData[recIdx]));
        end
        assert (memOp_o == expMemOp[recIdx])
            else failValue($sformatf("memOp %0d at %h", memOp_o, retireAddr_o));
        if (expMemOp[recIdx] != 3'd0) begin
            assert (memAddr_o == expMemAddr[recIdx])
                else failValue($sformatf("memAddr %h at %h", memAddr_o, retireAddr_o));
        end
        if (expMemOp[recIdx] == 3'd2) begin
            assert (storeData_o == expStoreData[recIdx])
                else failValue($sformatf("storeData %h at %h", storeData_o, retireAddr_o));
        end
        assert (cp0WriteEn_o == expCp0En[recIdx])
            else failValue($sformatf("cp0WriteEn %b at %h", cp0WriteEn_o, retireAddr_o));
        if (expCp0En[recIdx]) begin
            assert (cp0Addr_o == expCp0Addr[recIdx] && cp0Data_o == expCp0Data[recIdx])
                else failValue($sformatf("CP0 write %0d=%h at %h", cp0Addr_o, cp0Data_o,
                                         retireAddr_o));
        end
        recIdx++;
    endtask

    // Without a retire no write strobe may be active
    task automatic checkNoStrobe();
        assert (!wbEn_o && !cp0WriteEn_o && memOp_o == 3'd0)
            else failValue($sformatf("strobe without retire: wbEn %b cp0 %b memOp %0d",
                                     wbEn_o, cp0WriteEn_o, memOp_o));
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rstN_i && retire_o) begin
            checkRetire();
        end else if (rstN_i) begin
            checkNoStrobe();
        end
    end

    task automatic randomStall();
        stall_i = (($unsigned($random(seed)) % 5) == 0);
    endtask

    initial begin
        int waitCount;
        clk        = 1'b0;
        rstN_i     = 1'b0;
        insValid_i = 1'b0;
        ins_i      = '0;
        insAddr_i  = '0;
        stall_i    = 1'b0;
        recIdx     = 0;
        seed       = 32'he5d8;
        loadGolden();

        repeat (16) @(posedge clk);
        #2;
        rstN_i = 1'b1;

        for (int n = 0; n < progIns.size(); n++) begin
            insValid_i = 1'b1;
            ins_i      = progIns[n];
            insAddr_i  = progAddr[n];
            randomStall();
            waitCount  = 0;
            accepted   = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                accepted = insValid_i && insReady_o;
                @(posedge clk);
                #2;
                if (!accepted) begin
                    randomStall();
                    waitCount++;
                    if (waitCount >= timeoutCycles) begin
                        $display("Timed out waiting for the DUT to accept address %h",
                                 progAddr[n]);
                        $display("TESTBENCH FAILED");
                        $fatal(1, "input timeout");
                    end
                end
            end
        end
        insValid_i = 1'b0;

        waitCount = 0;
        while (recIdx < expAddr.size() && waitCount < timeoutCycles) begin
            @(posedge clk);
            #2;
            randomStall();
            waitCount++;
        end
        stall_i = 1'b0;
        repeat (5) @(posedge clk);

        if (recIdx == expAddr.size()) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("Timed out waiting for retire records, %0d of %0d seen",
                     recIdx, expAddr.size());
            $display("TESTBENCH FAILED");
            $fatal(1, "retire timeout");
        end
    end

endmodule

// ==== tests/golden_vectors.txt ====
# I <address> <instruction word>
# R <address> <wbEn> <wbAddr> <wbData> <memOp> <memAddr> <storeData> <cp0En> <cp0Addr> <cp0Data> <exc> <badVAddr>
I 00000100 34011234
I 00000104 3C028000
I 00000108 2023FFFC
I 0000010C 00622021
I 00000110 00232822
I 00000114 00813024
I 00000118 00C13826
I 0000011C 0081402A
I 00000120 00084900
I 00000124 00290025
I 00000128 00095021
I 0000012C 340B7FFF
I 00000130 004B0018
I 00000134 00006010
I 00000138 00006812
I 0000013C 00427020
I 00000140 340F0001
I 00000144 FC000000
I 00000148 340F0002
I 0000014C 340F0200
I 00000150 ADED0004
I 00000154 8DF00008
I 00000158 ADE10002
I 0000015C 34110003
I 00000160 408C6000
I 00000164 018D9021
I 00000168 024A9821
R 00000100 1 01 00001234 0 00000000 00000000 0 00 00000000 0 00000000
R 00000104 1 02 80000000 0 00000000 00000000 0 00 00000000 0 00000000
R 00000108 1 03 00001230 0 00000000 00000000 0 00 00000000 0 00000000
R 0000010C 1 04 80001230 0 00000000 00000000 0 00 00000000 0 00000000
R 00000110 1 05 00000004 0 00000000 00000000 0 00 00000000 0 00000000
R 00000114 1 06 00001230 0 00000000 00000000 0 00 00000000 0 00000000
R 00000118 1 07 00000004 0 00000000 00000000 0 00 00000000 0 00000000
R 0000011C 1 08 00000001 0 00000000 00000000 0 00 00000000 0 00000000
R 00000120 1 09 00000010 0 00000000 00000000 0 00 00000000 0 00000000
R 00000124 1 00 00001234 0 00000000 00000000 0 00 00000000 0 00000000
R 00000128 1 0A 00000010 0 00000000 00000000 0 00 00000000 0 00000000
R 0000012C 1 0B 00007FFF 0 00000000 00000000 0 00 00000000 0 00000000
R 00000130 0 00 00000000 0 00000000 00000000 0 00 00000000 0 00000000
R 00000134 1 0C FFFFC000 0 00000000 00000000 0 00 00000000 0 00000000
R 00000138 1 0D 80000000 0 00000000 00000000 0 00 00000000 0 00000000
R 0000013C 0 00 00000000 0 00000000 00000000 0 00 00000000 C 00000000
R 00000144 0 00 00000000 0 00000000 00000000 0 00 00000000 A 00000000
R 0000014C 1 0F 00000200 0 00000000 00000000 0 00 00000000 0 00000000
R 00000150 0 00 00000000 2 00000204 80000000 0 00 00000000 0 00000000
R 00000154 0 00 00000000 1 00000208 00000000 0 00 00000000 0 00000000
R 00000158 0 00 00000000 0 00000000 00000000 0 00 00000000 5 00000202
R 00000160 0 00 00000000 0 00000000 00000000 1 0C FFFFC000 0 00000000
R 00000164 1 12 7FFFC000 0 00000000 00000000 0 00 00000000 0 00000000
R 00000168 1 13 7FFFC010 0 00000000 00000000 0 00 00000000 0 00000000
